// ==== source/adpcma_pkg.sv ====
/*
  ADPCM-A shared definitions
  widths, frame constants and the decoder and gain tables
  used across the six-channel playback block
*/
package adpcma_pkg;

    localparam int num_ch          = 6;
    localparam int slots_per_frame = 18;   // 6 channels x 3 phases

    typedef logic        [2:0]  ch_t;       // channel index
    typedef logic        [4:0]  slot_t;     // 0..17
    typedef logic        [15:0] page_t;     // 256-byte pages
    typedef logic        [19:0] rom_addr_t; // low byte address
    typedef logic        [3:0]  bank_t;     // high address
    typedef logic        [3:0]  nibble_t;
    typedef logic signed [11:0] dec_t;      // decoder output
    typedef logic signed [15:0] pcm_t;
    typedef logic        [5:0]  step_idx_t; // 0..48
    typedef logic        [6:0]  atten_t;

    // step sizes, roughly 1.1x per entry
    localparam logic [10:0] step_table [49] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    // index step per magnitude code
    localparam logic signed [3:0] index_adj [8] = '{
        -4'sd1, -4'sd1, -4'sd1, -4'sd1, 4'sd2, 4'sd5, 4'sd7, 4'sd9
    };

    // 2^(-k/8) in 8-bit fixed point, one octave of attenuation
    localparam logic [7:0] gain_mant [8] = '{
        8'd255, 8'd235, 8'd215, 8'd197, 8'd181, 8'd166, 8'd152, 8'd140
    };

endpackage

// ==== source/adpcma_addr_cnt.sv ====
/*
  ADPCM-A address counter
  per-channel start, end and current byte addresses, nibble select,
  run bits and end flags; one channel served per fetch slot
*/
module adpcma_addr_cnt import adpcma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen_fetch,
    input  ch_t        ch,
    input  logic       wr_start,
    input  logic       wr_end,
    input  ch_t        wr_ch,
    input  page_t      wr_page,
    input  logic       key_on,
    input  logic       key_off,
    output rom_addr_t  addr,
    output bank_t      bank,
    output logic       roe_n,
    output logic       nib_sel,   // 0 high nibble, 1 low nibble
    output logic       chon,
    output logic [5:0] flags
);

    page_t             start_pg [num_ch];
    page_t             end_pg   [num_ch];
    logic [23:0]       cur      [num_ch];   // byte address
    logic [num_ch-1:0] sel;
    logic [num_ch-1:0] run;
    logic [23:0]       last_byte;
    logic              at_end;

    // register file writes, any clock
    always_ff @(posedge clk) begin
        if (wr_start && wr_ch < ch_t'(num_ch)) begin
            start_pg[wr_ch] <= wr_page;
        end
        if (wr_end && wr_ch < ch_t'(num_ch)) begin
            end_pg[wr_ch] <= wr_page;
        end
    end

    assign last_byte = {end_pg[ch], 8'hff};
    assign at_end    = sel[ch] && (cur[ch] == last_byte);   // low nibble of last byte

    // current address, steps after the low nibble
    always_ff @(posedge clk) begin
        if (cen_fetch) begin
            if (key_on) begin
                cur[ch] <= {start_pg[ch], 8'h00};
            end else if (!key_off && run[ch] && sel[ch] && !at_end) begin
                cur[ch] <= cur[ch] + 24'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel   <= '0;
            run   <= '0;
            flags <= '0;
        end else if (cen_fetch) begin
            if (key_on) begin
                sel[ch]   <= 1'b0;   // restart on high nibble
                run[ch]   <= 1'b1;
                flags[ch] <= 1'b0;
            end else if (key_off) begin
                run[ch] <= 1'b0;
            end else if (run[ch]) begin
                sel[ch] <= ~sel[ch];
                if (at_end) begin
                    run[ch]   <= 1'b0;   // sample done
                    flags[ch] <= 1'b1;
                end
            end
        end
    end

    // outputs follow the channel in service
    assign addr    = cur[ch][19:0];
    assign bank    = cur[ch][23:20];
    assign chon    = run[ch];
    assign roe_n   = ~run[ch];
    assign nib_sel = sel[ch];

endmodule

// ==== source/adpcma_decoder.sv ====
/*
  ADPCM-A nibble decoder
  one shared datapath, per-channel 12-bit accumulator and step index,
  updated in the channel's decode slot
*/
module adpcma_decoder import adpcma_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen_dec,
    input  ch_t     ch,
    input  logic    chon,
    input  logic    ch_reset,   // key-on restart
    input  nibble_t nibble,
    output dec_t    sample
);

    dec_t              acc [num_ch];
    step_idx_t         idx [num_ch];
    logic [10:0]       step;
    logic [13:0]       prod;
    logic [11:0]       mag;
    dec_t              acc_nx;
    logic signed [7:0] idx_sum;
    step_idx_t         idx_nx;

    always_comb begin
        step = step_table[idx[ch]];
        // (2n+1) * step / 8, written as (n*step + step/2) / 4
        prod = 14'(step) * 14'(nibble[2:0]) + 14'(step >> 1);
        mag  = prod[13:2];
        if (nibble[3]) begin
            acc_nx = acc[ch] - dec_t'(mag);   // 12-bit wrap
        end else begin
            acc_nx = acc[ch] + dec_t'(mag);
        end
        idx_sum = signed'({2'b00, idx[ch]}) + index_adj[nibble[2:0]];
        if (idx_sum < 8'sd0) begin
            idx_nx = '0;
        end else if (idx_sum > 8'sd48) begin
            idx_nx = 6'd48;   // top of table
        end else begin
            idx_nx = idx_sum[5:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                acc[i] <= '0;
                idx[i] <= '0;
            end
        end else if (cen_dec) begin
            if (ch_reset) begin
                acc[ch] <= '0;
                idx[ch] <= '0;
            end else if (chon) begin
                acc[ch] <= acc_nx;
                idx[ch] <= idx_nx;
            end
            // stopped channel keeps its last value
        end
    end

    assign sample = acc[ch];   // valid from the gain slot on

endmodule

// ==== source/adpcma_gain.sv ====
/*
  ADPCM-A level and pan
  stores the pan and level register of each channel and attenuates
  the decoded sample in 0.75 dB steps, left and right
*/
module adpcma_gain import adpcma_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen_gain,
    input  ch_t        ch,
    input  logic       wr_lracl,
    input  ch_t        wr_ch,
    input  logic [7:0] lracl,   // l, r, -, level[4:0]
    input  logic [5:0] atl,
    input  dec_t       sample_in,
    output pcm_t       out_l,
    output pcm_t       out_r
);

    logic [7:0]         lracl_mem [num_ch];
    logic [7:0]         cur_lracl;
    atten_t             atten;
    logic [8:0]         gain;
    pcm_t               sample16;
    logic signed [25:0] prod;
    pcm_t               scaled;

    // pan off and level zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ch; i++) begin
                lracl_mem[i] <= '0;
            end
        end else if (wr_lracl && wr_ch < ch_t'(num_ch)) begin
            lracl_mem[wr_ch] <= lracl;
        end
    end

    always_comb begin
        cur_lracl = lracl_mem[ch];
        // total attenuation, 0 is loudest
        atten    = (7'd63 - {1'b0, atl}) + (7'd31 - {2'b00, cur_lracl[4:0]});
        gain     = {1'b0, gain_mant[atten[2:0]]} >> atten[6:3];   // octave shift
        sample16 = {sample_in, 4'b0000};
        prod     = sample16 * signed'({1'b0, gain});
        scaled   = prod[23:8];
    end

    // sample only valid on the gain strobe
    assign out_l = (cen_gain && cur_lracl[7]) ? scaled : '0;
    assign out_r = (cen_gain && cur_lracl[6]) ? scaled : '0;

endmodule

// ==== source/adpcma_mixer.sv ====
/*
  ADPCM-A channel mixer
  sums the six channel samples of a frame, left and right,
  and updates the saturated outputs once per frame
*/
module adpcma_mixer import adpcma_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic cen_acc,
    input  logic frame_end,   // level, slot 17
    input  pcm_t in_l,
    input  pcm_t in_r,
    output pcm_t pcm_l,
    output pcm_t pcm_r
);

    logic signed [18:0] acc_l, acc_r;
    logic signed [18:0] sum_l, sum_r;

    function automatic pcm_t sat16(input logic signed [18:0] v);
        if (v > 19'sd32767) begin
            return 16'sh7fff;
        end else if (v < -19'sd32768) begin
            return 16'sh8000;
        end
        return v[15:0];
    endfunction

    assign sum_l = acc_l + 19'(in_l);   // sign extended
    assign sum_r = acc_r + 19'(in_r);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_l <= '0;
            acc_r <= '0;
            pcm_l <= '0;
            pcm_r <= '0;
        end else if (cen_acc) begin
            if (frame_end) begin
                pcm_l <= sat16(sum_l);
                pcm_r <= sat16(sum_r);
                acc_l <= '0;   // next frame starts clean
                acc_r <= '0;
            end else begin
                acc_l <= sum_l;
                acc_r <= sum_r;
            end
        end
    end

endmodule

// ==== source/adpcma_drv.sv ====
/*
  ADPCM-A driver, six channels
  runs the 18-slot frame sequencer, captures register writes and key
  commands, selects the nibble from the fetched ROM byte and ties the
  address counter, decoder, gain and mixer together
*/
module adpcma_drv import adpcma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    output rom_addr_t   addr,
    output bank_t       bank,
    output logic        roe_n,
    input  logic [7:0]  data_in,
    input  logic [5:0]  atl,       // total level
    input  page_t       addr_in,
    input  logic [7:0]  lracl_in,
    input  ch_t         up_addr,
    input  logic        up_start,
    input  logic        up_end,
    input  logic        up_lracl,
    input  logic        aon_we,
    input  logic [7:0]  aon_cmd,   // bit 7 key off, bits 5:0 channel mask
    output logic [5:0]  flags,
    output pcm_t        pcm_l,
    output pcm_t        pcm_r
);

    slot_t       slot;
    ch_t         ch;
    logic [1:0]  phase;
    logic        fetch_ph;
    logic        cen_fetch, cen_dec, cen_gain;
    logic        frame_end;

    logic        wr_start, wr_end, wr_lracl;
    ch_t         wr_ch;
    page_t       wr_page;
    logic [7:0]  wr_lracl_data;

    logic [num_ch-1:0] on_pend, off_pend, fetch_mask;
    logic        key_on, key_off;

    logic        cnt_roe_n, nib_sel, chon;
    nibble_t     nibble_q;
    logic        chon_q, reset_q;
    dec_t        sample;
    pcm_t        gain_l, gain_r;

    // slot sequencer, one step per cen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (cen) begin
            slot <= (slot == slot_t'(slots_per_frame - 1)) ? '0 : slot + 5'd1;
        end
    end

    assign ch        = ch_t'(slot / 5'd3);
    assign phase     = 2'(slot % 5'd3);
    assign fetch_ph  = (phase == 2'd0);
    assign cen_fetch = cen & fetch_ph;
    assign cen_dec   = cen & (phase == 2'd1);
    assign cen_gain  = cen & (phase == 2'd2);
    assign frame_end = (slot == slot_t'(slots_per_frame - 1));   // last slot

    // write strobes delayed one clock, data alongside
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_start <= 1'b0;
            wr_end   <= 1'b0;
            wr_lracl <= 1'b0;
        end else begin
            wr_start <= up_start;
            wr_end   <= up_end;
            wr_lracl <= up_lracl;
        end
    end

    always_ff @(posedge clk) begin
        wr_ch         <= up_addr;
        wr_page       <= addr_in;
        wr_lracl_data <= lracl_in;
    end

    // pending key commands, consumed at the channel's fetch slot
    assign fetch_mask = cen_fetch ? (num_ch'(1) << ch) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            on_pend  <= '0;
            off_pend <= '0;
        end else if (aon_we && aon_cmd[7]) begin
            off_pend <= (off_pend & ~fetch_mask) | aon_cmd[5:0];
            on_pend  <= on_pend & ~fetch_mask & ~aon_cmd[5:0];   // latest wins
        end else if (aon_we) begin
            on_pend  <= (on_pend & ~fetch_mask) | aon_cmd[5:0];
            off_pend <= off_pend & ~fetch_mask & ~aon_cmd[5:0];
        end else begin
            on_pend  <= on_pend & ~fetch_mask;
            off_pend <= off_pend & ~fetch_mask;
        end
    end

    assign key_on  = fetch_ph & on_pend[ch];
    assign key_off = fetch_ph & off_pend[ch];

    // ROM read only inside the fetch slot
    assign roe_n = cnt_roe_n | ~fetch_ph;

    // byte sampled at the end of the fetch slot, high nibble first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nibble_q <= '0;
            chon_q   <= 1'b0;
            reset_q  <= 1'b0;
        end else if (cen_fetch) begin
            nibble_q <= chon ? (nib_sel ? data_in[3:0] : data_in[7:4]) : '0;
            chon_q   <= chon;
            reset_q  <= key_on;   // clears decoder state next slot
        end
    end

    adpcma_addr_cnt i_addr_cnt (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen_fetch ( cen_fetch ),
        .ch        ( ch        ),
        .wr_start  ( wr_start  ),
        .wr_end    ( wr_end    ),
        .wr_ch     ( wr_ch     ),
        .wr_page   ( wr_page   ),
        .key_on    ( key_on    ),
        .key_off   ( key_off   ),
        .addr      ( addr      ),
        .bank      ( bank      ),
        .roe_n     ( cnt_roe_n ),
        .nib_sel   ( nib_sel   ),
        .chon      ( chon      ),
        .flags     ( flags     )
    );

    adpcma_decoder i_decoder (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen_dec  ( cen_dec  ),
        .ch       ( ch       ),
        .chon     ( chon_q   ),
        .ch_reset ( reset_q  ),
        .nibble   ( nibble_q ),
        .sample   ( sample   )
    );

    adpcma_gain i_gain (
        .clk       ( clk           ),
        .rst_n     ( rst_n         ),
        .cen_gain  ( cen_gain      ),
        .ch        ( ch            ),
        .wr_lracl  ( wr_lracl      ),
        .wr_ch     ( wr_ch         ),
        .lracl     ( wr_lracl_data ),
        .atl       ( atl           ),
        .sample_in ( sample        ),
        .out_l     ( gain_l        ),
        .out_r     ( gain_r        )
    );

    adpcma_mixer i_mixer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .cen_acc   ( cen_gain  ),
        .frame_end ( frame_end ),
        .in_l      ( gain_l    ),
        .in_r      ( gain_r    ),
        .pcm_l     ( pcm_l     ),
        .pcm_r     ( pcm_r     )
    );

endmodule

// ==== sim/adpcma_rom_model.sv ====
/*
  sample ROM model
  64 KB byte array behind the flat ROM address, answers
  combinationally while the read enable is low; the testbench
  writes the contents
*/
module adpcma_rom_model import adpcma_pkg::*; (
    input  rom_addr_t  addr,
    input  bank_t      bank,
    input  logic       roe_n,
    output logic [7:0] data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [65536];
    logic       in_range;

    // only the lowest 64 KB are populated
    assign in_range = (bank == 4'd0) && (addr[19:16] == 4'd0);
    assign data     = (!roe_n && in_range) ? mem[addr[15:0]] : 8'h00;   // idle bus reads zero

endmodule

// ==== sim/adpcma_tb.sv ====
/*
  ADPCM-A driver testbench
  drives register writes and key commands into the six-channel driver,
  serves sample bytes from a ROM model and checks ROM addresses, end
  flags, decoding direction, pan and key-off with immediate assertions
*/
module adpcma_tb import adpcma_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int frame_clks  = 4 * slots_per_frame;   // cen every 4 clocks
    // frames per test: reset, address, end flag, sign, pan, key-off
    localparam int test_frames = 4 + 18 + 530 + 20 + 18 + 14;
    localparam int max_cycles  = 10 + (test_frames + 20) * frame_clks;
    // nibble 7 at step index 0 is (16*7 + 8)/4, then x16 and full gain 255/256
    localparam int first_pcm   = ((16 * 7 + 16 / 2) / 4) * 16 * 255 / 256;

    logic       clk, rst_n, cen;
    rom_addr_t  addr;
    bank_t      bank;
    logic       roe_n;
    logic [7:0] data_in, lracl_in, aon_cmd;
    logic [5:0] atl, flags;
    page_t      addr_in;
    ch_t        up_addr;
    logic       up_start, up_end, up_lracl, aon_we;
    pcm_t       pcm_l, pcm_r;

    logic [1:0]  cen_div;
    slot_t       tb_slot;    // frame position seen by the testbench
    int          cycles, checks, errors, test_errs, tests_ok, tests_bad, test_no;
    logic [31:0] rnd;

    always #20 clk = ~clk;

    // one cen clock out of four, driven just after the edge
    always @(posedge clk) begin
        #2;
        cen_div <= cen_div + 2'd1;
        cen     <= (cen_div == 2'd3);
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tb_slot <= '0;
        end else if (cen) begin
            tb_slot <= (tb_slot == slot_t'(slots_per_frame - 1)) ? '0 : tb_slot + 5'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: test %0d still running after %0d cycles", test_no, cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    adpcma_drv i_adpcma_drv (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .addr     ( addr     ),
        .bank     ( bank     ),
        .roe_n    ( roe_n    ),
        .data_in  ( data_in  ),
        .atl      ( atl      ),
        .addr_in  ( addr_in  ),
        .lracl_in ( lracl_in ),
        .up_addr  ( up_addr  ),
        .up_start ( up_start ),
        .up_end   ( up_end   ),
        .up_lracl ( up_lracl ),
        .aon_we   ( aon_we   ),
        .aon_cmd  ( aon_cmd  ),
        .flags    ( flags    ),
        .pcm_l    ( pcm_l    ),
        .pcm_r    ( pcm_r    )
    );

    adpcma_rom_model i_adpcma_rom_model (
        .addr  ( addr    ),
        .bank  ( bank    ),
        .roe_n ( roe_n   ),
        .data  ( data_in )
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("** Error at %0d ns: %s", $time, msg);
        end
    endtask

    // negedge in slot s, the clock that carries its cen
    task automatic wait_slot(input int s);
        do begin
            @(negedge clk);
        end while (!(cen && tb_slot == slot_t'(s)));
    endtask

    task automatic set_pages(input ch_t ch, input page_t first, input page_t last);
        @(posedge clk);
        #2;
        up_addr  = ch;
        addr_in  = first;
        up_start = 1'b1;
        @(posedge clk);
        #2;
        up_start = 1'b0;
        addr_in  = last;
        up_end   = 1'b1;
        @(posedge clk);
        #2;
        up_end = 1'b0;
    endtask

    task automatic set_lracl(input ch_t ch, input logic [7:0] val);
        @(posedge clk);
        #2;
        up_addr  = ch;
        lracl_in = val;
        up_lracl = 1'b1;
        @(posedge clk);
        #2;
        up_lracl = 1'b0;
    endtask

    // issued right after the channel's fetch slot, so it acts next frame
    task automatic key_cmd(input int ch, input logic off);
        wait_slot(3 * ch);
        @(posedge clk);
        #2;
        aon_cmd = {off, 1'b0, 6'(1 << ch)};
        aon_we  = 1'b1;
        @(posedge clk);
        #2;
        aon_we = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors - test_errs;
        if (n == 0) begin
            tests_ok++;
            $display("test %0d %s: ok", test_no, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", test_no, name, n);
        end
        test_no++;
        test_errs = errors;
    endtask

    initial begin
        pcm_t        prev;
        pcm_t        prev_r;
        logic [23:0] exp_addr;
        int          fetches;
        logic        stopped;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cen       = 1'b0;
        cen_div   = 2'd0;
        atl       = 6'd63;   // total level at max
        addr_in   = '0;
        lracl_in  = '0;
        up_addr   = '0;
        up_start  = 1'b0;
        up_end    = 1'b0;
        up_lracl  = 1'b0;
        aon_we    = 1'b0;
        aon_cmd   = '0;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        tests_ok  = 0;
        tests_bad = 0;
        test_no   = 1;
        rnd       = 32'h8aaf2761;
        for (int a = 0; a < 65536; a++) begin
            rnd = xorshift32(rnd);
            i_adpcma_rom_model.mem[a] = rnd[7:0] ^ a[15:8];
        end
        for (int i = 0; i < 256; i++) begin
            i_adpcma_rom_model.mem[16'h3000 + i] = 8'h77;   // rising nibbles
            i_adpcma_rom_model.mem[16'h3100 + i] = 8'hff;   // falling nibbles
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < 3 * slots_per_frame; i++) begin
            wait_slot(i % slots_per_frame);
            expect_equal("roe_n", roe_n, 1'b1);
            expect_equal("flags", flags, 6'd0);
            expect_equal("pcm_l", pcm_l, 16'd0);
            expect_equal("pcm_r", pcm_r, 16'd0);
        end
        finish_test("reset state");

        set_pages(3'd2, 16'h0012, 16'h0013);
        key_cmd(2, 1'b0);
        wait_slot(6);
        expect_equal("roe_n", roe_n, 1'b1);   // key-on slot, reads start next frame
        for (int i = 0; i < 12; i++) begin
            wait_slot(6);
            exp_addr = 24'h001200 + 24'(i / 2);   // each byte twice
            expect_equal("roe_n", roe_n, 1'b0);
            expect_equal("addr", addr, exp_addr[19:0]);
            expect_equal("bank", bank, exp_addr[23:20]);
        end
        key_cmd(2, 1'b1);
        finish_test("address sequence");

        set_pages(3'd2, 16'h0020, 16'h0020);
        key_cmd(2, 1'b0);
        wait_slot(6);
        fetches = 0;
        stopped = 1'b0;
        while (!stopped && fetches < 520) begin
            wait_slot(6);
            if (!roe_n) begin
                exp_addr = 24'h002000 + 24'(fetches / 2);
                expect_equal("addr", addr, exp_addr[19:0]);
                expect_equal("bank", bank, exp_addr[23:20]);
                fetches++;
            end else begin
                stopped = 1'b1;
            end
        end
        expect_equal("nibble fetches", fetches, 512);   // 256 bytes, two nibbles each
        expect_equal("flags", flags, 6'b000100);
        repeat (2) begin
            wait_slot(6);
            expect_equal("roe_n", roe_n, 1'b1);
            expect_equal("flags[2]", flags[2], 1'b1);
        end
        key_cmd(2, 1'b0);
        wait_slot(6);
        wait_slot(7);   // just past the key-on slot
        expect_equal("flags[2]", flags[2], 1'b0);
        key_cmd(2, 1'b1);
        finish_test("end and flag");

        set_pages(3'd0, 16'h0030, 16'h0030);
        set_lracl(3'd0, 8'hdf);   // both sides, level 31
        key_cmd(0, 1'b0);
        wait_slot(0);
        wait_slot(0);
        expect_equal("pcm_l", pcm_l, 16'd0);   // key-on frame decodes nothing
        prev   = pcm_l;
        prev_r = pcm_r;
        for (int i = 0; i < 5; i++) begin
            wait_slot(0);
            if (i == 0) begin
                expect_equal("pcm_l", pcm_l, first_pcm);
                expect_equal("pcm_r", pcm_r, first_pcm);
            end
            require(pcm_l > prev, $sformatf("pcm_l did not rise, %0d after %0d", pcm_l, prev));
            require(pcm_r > prev_r,
                    $sformatf("pcm_r did not rise, %0d after %0d", pcm_r, prev_r));
            require(!pcm_l[15], $sformatf("pcm_l went negative, %0d", pcm_l));
            prev   = pcm_l;
            prev_r = pcm_r;
        end
        set_pages(3'd0, 16'h0031, 16'h0031);
        key_cmd(0, 1'b0);
        wait_slot(0);
        wait_slot(0);
        expect_equal("pcm_l", pcm_l, 16'd0);   // decoder cleared by key-on
        prev = pcm_l;
        for (int i = 0; i < 5; i++) begin
            wait_slot(0);
            require(pcm_l < prev, $sformatf("pcm_l did not fall, %0d after %0d", pcm_l, prev));
            require(pcm_l[15], $sformatf("pcm_l not negative, %0d", pcm_l));
            prev = pcm_l;
        end
        finish_test("sign of decoding");

        set_pages(3'd0, 16'h0030, 16'h0030);
        set_lracl(3'd0, 8'h9f);   // left only
        key_cmd(0, 1'b0);
        wait_slot(0);
        wait_slot(0);
        expect_equal("pcm_r", pcm_r, 16'd0);
        prev = pcm_l;
        for (int i = 0; i < 4; i++) begin
            wait_slot(0);
            expect_equal("pcm_r", pcm_r, 16'd0);
            require(pcm_l != prev, $sformatf("pcm_l stuck at %0d", pcm_l));
            prev = pcm_l;
        end
        set_lracl(3'd0, 8'h1f);   // no side enabled
        key_cmd(0, 1'b0);
        wait_slot(0);
        for (int i = 0; i < 5; i++) begin
            wait_slot(0);
            expect_equal("pcm_l", pcm_l, 16'd0);
            expect_equal("pcm_r", pcm_r, 16'd0);
        end
        finish_test("pan");

        set_lracl(3'd0, 8'hdf);
        key_cmd(0, 1'b0);
        wait_slot(0);
        repeat (3) wait_slot(0);
        key_cmd(0, 1'b1);
        wait_slot(0);   // key-off slot still reads its nibble
        wait_slot(0);
        expect_equal("roe_n", roe_n, 1'b1);
        prev = pcm_l;
        require(pcm_l != 16'd0, "pcm_l is zero although channel 0 was playing");
        for (int i = 0; i < 4; i++) begin
            wait_slot(0);
            expect_equal("roe_n", roe_n, 1'b1);
            expect_equal("pcm_l", pcm_l, prev);
        end
        finish_test("key-off");

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
source/adpcma_pkg.sv
source/adpcma_addr_cnt.sv
source/adpcma_decoder.sv
source/adpcma_gain.sv
source/adpcma_mixer.sv
source/adpcma_drv.sv
sim/adpcma_rom_model.sv
sim/adpcma_tb.sv

// ==== Makefile ====
TOP := adpcma_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
